// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tbMemSubsystem
RTL_TOP   ?= memSubsystem
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: project.f
verilog/memPkg.sv
verilog/reqArbiter.sv
verilog/byteSeq.sv
verilog/byteRam.sv
verilog/memSubsystem.sv
sim/tbMemSubsystem.sv

// File: sim/tbMemSubsystem.sv
`timescale 1ns/1ps

module tbMemSubsystem
    import memPkg::*;
();

    localparam int AddrWidth = 10;
    localparam int Depth     = 1 << AddrWidth;
    localparam int NumTests  = 19;
    localparam int ClkPeriod = 40;
    localparam int DoneLimit = 40;

    typedef enum logic [1:0] {
        cliData,
        cliFetch,
        cliBoth
    } clientT;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 stall;
    logic                 fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [WordWidth-1:0] fetchInst;
    logic                 dataEn;
    memOpT                dataOp;
    lenT                  dataLen;
    logic [AddrWidth-1:0] dataAddr;
    logic [WordWidth-1:0] dataWdata;
    logic                 dataDone;
    logic [WordWidth-1:0] dataRdata;

    // stimulus table with one array per column
    string                tName   [NumTests];
    clientT               tClient [NumTests];
    memOpT                tOp     [NumTests];
    lenT                  tLen    [NumTests];
    logic [AddrWidth-1:0] tAddr   [NumTests];
    logic [WordWidth-1:0] tWdata  [NumTests];
    logic                 tStall  [NumTests];
    int                   numEntries;

    // expected RAM contents
    logic [ByteWidth-1:0] refMem [Depth];
    integer               seed = 56;

    memSubsystem #(.AddrWidth(AddrWidth)) dut_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataEn    (dataEn),
        .dataOp    (dataOp),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic stopRun();
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic addEntry(input string name, input clientT cli, input memOpT op,
                            input lenT len, input logic [AddrWidth-1:0] addr,
                            input logic stallFlag);
        tName[numEntries]   = name;
        tClient[numEntries] = cli;
        tOp[numEntries]     = op;
        tLen[numEntries]    = len;
        tAddr[numEntries]   = addr;
        tWdata[numEntries]  = $random(seed);
        tStall[numEntries]  = stallFlag;
        numEntries++;
    endtask

    task automatic buildTable();
        addEntry("store4 0x040", cliData, opStore, 3'd4, 10'h040, 1'b0);
        addEntry("load4 0x040", cliData, opLoad, 3'd4, 10'h040, 1'b0);
        addEntry("load1 0x040", cliData, opLoad, 3'd1, 10'h040, 1'b0);
        addEntry("load2 0x040", cliData, opLoad, 3'd2, 10'h040, 1'b0);
        addEntry("load1 0x043", cliData, opLoad, 3'd1, 10'h043, 1'b0);
        addEntry("store4 0x100", cliData, opStore, 3'd4, 10'h100, 1'b0);
        addEntry("store1 0x101", cliData, opStore, 3'd1, 10'h101, 1'b0);
        addEntry("load4 after store1", cliData, opLoad, 3'd4, 10'h100, 1'b0);
        addEntry("store2 0x102", cliData, opStore, 3'd2, 10'h102, 1'b0);
        addEntry("load4 after store2", cliData, opLoad, 3'd4, 10'h100, 1'b0);
        addEntry("fetch 0x040", cliFetch, opFetch, 3'd4, 10'h040, 1'b0);
        addEntry("fetch 0x101", cliFetch, opFetch, 3'd4, 10'h101, 1'b0);
        addEntry("data and fetch 0x200", cliBoth, opStore, 3'd4, 10'h200, 1'b0);
        addEntry("stalled load4 0x200", cliData, opLoad, 3'd4, 10'h200, 1'b1);
        addEntry("stalled store4 0x300", cliData, opStore, 3'd4, 10'h300, 1'b1);
        addEntry("load4 0x300", cliData, opLoad, 3'd4, 10'h300, 1'b0);
        addEntry("store2 wrap 0x3ff", cliData, opStore, 3'd2, 10'h3ff, 1'b0);
        addEntry("load2 wrap 0x3ff", cliData, opLoad, 3'd2, 10'h3ff, 1'b0);
        addEntry("stalled load4 0x3fe", cliData, opLoad, 3'd4, 10'h3fe, 1'b1);
    endtask

    // little endian with zero fill above len
    function automatic logic [WordWidth-1:0] refWord(input logic [AddrWidth-1:0] addr,
                                                     input lenT len);
        logic [WordWidth-1:0] w;
        w = '0;
        for (int k = 0; k < int'(len); k++) begin
            w[k*ByteWidth +: ByteWidth] = refMem[(int'(addr) + k) % Depth];
        end
        return w;
    endfunction

    task automatic storeRef(input logic [AddrWidth-1:0] addr, input lenT len,
                            input logic [WordWidth-1:0] wdata);
        for (int k = 0; k < int'(len); k++) begin
            refMem[(int'(addr) + k) % Depth] = wdata[k*ByteWidth +: ByteWidth];
        end
    endtask

    task automatic compareWord(input string name, input logic [WordWidth-1:0] expWord,
                               input logic [WordWidth-1:0] actWord);
        if (actWord !== expWord) begin
            $display("ERR %s expected %h actual %h", name, expWord, actWord);
            stopRun();
        end
    endtask

    task automatic compareOwner(input string name, input ownerT expOwner,
                                input logic dDone, input logic fDone);
        ownerT actOwner;
        if (dDone && fDone) begin
            $display("%s: dataDone and fetchDone pulsed in the same cycle", name);
            stopRun();
        end
        actOwner = fDone ? ownFetch : ownData;
        if (actOwner != expOwner) begin
            $display("ERR %s expected %s actual %s", name, expOwner.name(), actOwner.name());
            stopRun();
        end
    endtask

    // returns at the falling edge where a done is high
    task automatic awaitDone(input string name, input logic useStall);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            seen = dataDone || fetchDone;
            if (seen && stall) begin
                $display("%s: done pulsed while stall was high", name);
                stopRun();
            end else if (!seen && cycles >= DoneLimit) begin
                $display("%s: no done pulse within %0d cycles", name, DoneLimit);
                stopRun();
            end else if (!seen) begin
                // stall window lands inside the byte sequence
                stall = useStall && cycles >= 2 && cycles < 7;
            end
        end
    endtask

    task automatic checkQuiet(input string name, input int numCycles);
        repeat (numCycles) begin
            @(negedge clk);
            if (dataDone || fetchDone) begin
                $display("%s: done stayed high or a request was served twice", name);
                stopRun();
            end
        end
    endtask

    task automatic runTest(input int i);
        ownerT expOwner;
        expOwner = (tClient[i] == cliFetch) ? ownFetch : ownData;
        if (tClient[i] != cliFetch) begin
            dataEn    = 1'b1;
            dataOp    = tOp[i];
            dataLen   = tLen[i];
            dataAddr  = tAddr[i];
            dataWdata = tWdata[i];
        end
        if (tClient[i] != cliData) begin
            fetchEn   = 1'b1;
            fetchAddr = tAddr[i];
        end
        awaitDone(tName[i], tStall[i]);
        compareOwner(tName[i], expOwner, dataDone, fetchDone);
        if (expOwner == ownFetch) begin
            compareWord(tName[i], refWord(tAddr[i], 3'd4), fetchInst);
        end else if (tOp[i] == opStore) begin
            storeRef(tAddr[i], tLen[i], tWdata[i]);
        end else begin
            compareWord(tName[i], refWord(tAddr[i], tLen[i]), dataRdata);
        end
        // enable stays up through the cycle after done
        checkQuiet(tName[i], 2);
        if (expOwner == ownFetch) begin
            fetchEn = 1'b0;
        end else begin
            dataEn = 1'b0;
        end
        // fetch waits behind the data store and must see the new bytes
        if (tClient[i] == cliBoth) begin
            awaitDone(tName[i], 1'b0);
            compareOwner(tName[i], ownFetch, dataDone, fetchDone);
            compareWord(tName[i], refWord(tAddr[i], 3'd4), fetchInst);
            checkQuiet(tName[i], 2);
            fetchEn = 1'b0;
        end
        // long enough for a repeated serve of a held request to complete
        checkQuiet(tName[i], 6);
    endtask

    initial begin
        rst        = 1'b1;
        stall      = 1'b0;
        fetchEn    = 1'b0;
        fetchAddr  = '0;
        dataEn     = 1'b0;
        dataOp     = opLoad;
        dataLen    = 3'd4;
        dataAddr   = '0;
        dataWdata  = '0;
        numEntries = 0;
        foreach (refMem[a]) begin
            refMem[a] = '0;
        end
        buildTable();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < numEntries; i++) begin
            runTest(i);
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        #(NumTests * 40 * ClkPeriod);
        $display("watchdog expired after %0d ns", NumTests * 40 * ClkPeriod);
        stopRun();
    end

endmodule

// File: verilog/byteRam.sv
`timescale 1ns/1ps

module byteRam import memPkg::*; #(
    parameter int AddrWidth = 10
) (
    input  logic                 clk,
    input  logic [AddrWidth-1:0] ramAddr,
    input  logic                 ramWe,
    input  logic [ByteWidth-1:0] ramWdata,
    output logic [ByteWidth-1:0] ramRdata
);

    localparam int Depth = 1 << AddrWidth;

    logic [ByteWidth-1:0] mem [0:Depth-1];

    // board memory powers up blank
    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old byte when writing the same address
    always @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWdata;
        end
        ramRdata <= mem[ramAddr];
    end

endmodule

// File: verilog/byteSeq.sv
`timescale 1ns/1ps

module byteSeq import memPkg::*; #(
    parameter int AddrWidth = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,

    input  logic                 start,
    input  memOpT                op,
    input  lenT                  len,
    input  logic [AddrWidth-1:0] addr,
    input  logic [WordWidth-1:0] wdata,
    output logic                 finish,
    output logic [WordWidth-1:0] rdata,

    output logic [AddrWidth-1:0] ramAddr,
    output logic                 ramWe,
    output logic [ByteWidth-1:0] ramWdata,
    input  logic [ByteWidth-1:0] ramRdata
);

    typedef enum logic [1:0] {
        seqIdle  = 2'd0,
        seqRead  = 2'd1,
        seqWrite = 2'd2,
        seqDone  = 2'd3
    } seqStateT;

    seqStateT             state;
    logic [2:0]           stage;
    logic [AddrWidth-1:0] addrQ;
    lenT                  lenQ;
    logic [WordWidth-1:0] wdataQ;
    logic [WordWidth-1:0] word;
    logic [1:0]           rdIdx;
    logic [1:0]           wrIdx;
    logic                 startStore;
    logic                 lastWrite;

    // byte returning in read stage k belongs to position k-1
    assign rdIdx = 2'(stage - 3'd1);
    assign wrIdx = stage[1:0];

    assign startStore = start && (op == opStore);
    assign lastWrite  = (state == seqWrite) && (stage == lenQ - 3'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            stage <= 3'd0;
        end else if (!stall) begin
            case (state)
                seqIdle: begin
                    if (start) begin
                        stage <= 3'd1;
                        if (op == opStore) begin
                            state <= (len == 3'd1) ? seqIdle : seqWrite;
                        end else begin
                            state <= seqRead;
                        end
                    end
                end
                seqRead: begin
                    stage <= stage + 3'd1;
                    if (stage == lenQ) begin
                        state <= seqDone;
                    end
                end
                seqWrite: begin
                    stage <= stage + 3'd1;
                    if (lastWrite) begin
                        state <= seqIdle;
                    end
                end
                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == seqIdle && start) begin
                addrQ  <= addr + AddrWidth'(1);
                lenQ   <= len;
                wdataQ <= wdata;
                // zero fill above len
                word   <= '0;
            end else begin
                addrQ <= addrQ + AddrWidth'(1);
                if (state == seqRead) begin
                    word[rdIdx*ByteWidth +: ByteWidth] <= ramRdata;
                end
            end
        end
    end

    // on stall re-issue the previous address so ramRdata keeps the pending byte
    always_comb begin
        if (start) begin
            ramAddr = addr;
        end else if (stall) begin
            ramAddr = addrQ - AddrWidth'(1);
        end else begin
            ramAddr = addrQ;
        end
    end

    assign ramWe    = !stall && (startStore || state == seqWrite);
    assign ramWdata = start ? wdata[ByteWidth-1:0] : wdataQ[wrIdx*ByteWidth +: ByteWidth];

    // stores finish in the last write cycle, loads one cycle after the last byte
    assign finish = !stall && ((startStore && len == 3'd1) || lastWrite
                               || state == seqDone);
    assign rdata  = word;

endmodule

// File: verilog/memPkg.sv
package memPkg;

    // data and instruction words
    localparam int WordWidth = 32;

    // one RAM location
    localparam int ByteWidth = 8;

    typedef enum logic [1:0] {
        opLoad  = 2'd0,
        opStore = 2'd1,
        opFetch = 2'd2
    } memOpT;

    // who gets the done pulse
    typedef enum logic {
        ownData  = 1'b0,
        ownFetch = 1'b1
    } ownerT;

    // access length in bytes, 1, 2 or 4
    typedef logic [2:0] lenT;

endpackage

// File: verilog/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem import memPkg::*; #(
    parameter int AddrWidth = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,

    input  logic                 fetchEn,
    input  logic [AddrWidth-1:0] fetchAddr,
    output logic                 fetchDone,
    output logic [WordWidth-1:0] fetchInst,

    input  logic                 dataEn,
    input  memOpT                dataOp,
    input  lenT                  dataLen,
    input  logic [AddrWidth-1:0] dataAddr,
    input  logic [WordWidth-1:0] dataWdata,
    output logic                 dataDone,
    output logic [WordWidth-1:0] dataRdata
);

    logic                 start;
    memOpT                op;
    lenT                  len;
    logic [AddrWidth-1:0] addr;
    logic [WordWidth-1:0] wdata;
    logic                 finish;
    logic [WordWidth-1:0] rdata;

    logic [AddrWidth-1:0] ramAddr;
    logic                 ramWe;
    logic [ByteWidth-1:0] ramWdata;
    logic [ByteWidth-1:0] ramRdata;

    reqArbiter #(.AddrWidth(AddrWidth)) arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataEn    (dataEn),
        .dataOp    (dataOp),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .start     (start),
        .op        (op),
        .len       (len),
        .addr      (addr),
        .wdata     (wdata),
        .finish    (finish),
        .rdata     (rdata)
    );

    byteSeq #(.AddrWidth(AddrWidth)) seq_i (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .start    (start),
        .op       (op),
        .len      (len),
        .addr     (addr),
        .wdata    (wdata),
        .finish   (finish),
        .rdata    (rdata),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam #(.AddrWidth(AddrWidth)) ram_i (
        .clk      (clk),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

// File: verilog/reqArbiter.sv
`timescale 1ns/1ps

module reqArbiter import memPkg::*; #(
    parameter int AddrWidth = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,

    input  logic                 fetchEn,
    input  logic [AddrWidth-1:0] fetchAddr,
    output logic                 fetchDone,
    output logic [WordWidth-1:0] fetchInst,

    input  logic                 dataEn,
    input  memOpT                dataOp,
    input  lenT                  dataLen,
    input  logic [AddrWidth-1:0] dataAddr,
    input  logic [WordWidth-1:0] dataWdata,
    output logic                 dataDone,
    output logic [WordWidth-1:0] dataRdata,

    output logic                 start,
    output memOpT                op,
    output lenT                  len,
    output logic [AddrWidth-1:0] addr,
    output logic [WordWidth-1:0] wdata,
    input  logic                 finish,
    input  logic [WordWidth-1:0] rdata
);

    logic                 busy;
    logic                 startPend;
    logic                 dataDoneQ;
    logic                 fetchDoneQ;
    ownerT                owner;
    logic                 dataReq;
    logic                 fetchReq;
    memOpT                opQ;
    lenT                  lenQ;
    logic [AddrWidth-1:0] addrQ;
    logic [WordWidth-1:0] wdataQ;

    // a client still holding enable right after its done is not served again
    assign dataReq  = dataEn && !dataDoneQ;
    assign fetchReq = fetchEn && !fetchDoneQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            startPend  <= 1'b0;
            dataDoneQ  <= 1'b0;
            fetchDoneQ <= 1'b0;
            owner      <= ownData;
        end else if (!stall) begin
            dataDoneQ  <= dataDone;
            fetchDoneQ <= fetchDone;
            if (!busy) begin
                if (dataReq || fetchReq) begin
                    busy      <= 1'b1;
                    startPend <= 1'b1;
                    owner     <= dataReq ? ownData : ownFetch;
                end
            end else begin
                startPend <= 1'b0;
                if (finish) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // request fields, data port wins
    always_ff @(posedge clk) begin
        if (!stall && !busy) begin
            if (dataReq) begin
                opQ    <= dataOp;
                lenQ   <= dataLen;
                addrQ  <= dataAddr;
                wdataQ <= dataWdata;
            end else if (fetchReq) begin
                opQ    <= opFetch;
                lenQ   <= 3'd4;
                addrQ  <= fetchAddr;
                wdataQ <= '0;
            end
        end
    end

    assign start = startPend && !stall;
    assign op    = opQ;
    assign len   = lenQ;
    assign addr  = addrQ;
    assign wdata = wdataQ;

    assign dataDone  = finish && (owner == ownData);
    assign fetchDone = finish && (owner == ownFetch);
    assign dataRdata = dataDone ? rdata : '0;
    assign fetchInst = fetchDone ? rdata : '0;

endmodule
